// ==== isq_cfg.svh ====
`ifndef ISQ_CFG_SVH
`define ISQ_CFG_SVH

// Queue depth in entries
`define ISQ_SIZE 8

// Dispatch lanes, writeback ports and ALU banks share this width
`define ISQ_DISPATCH_WIDTH 2

// Physical register tag width
`define ISQ_PREG_AW 6

// ROB index width
`define ISQ_ROB_AW 5

// Operand data width
`define ISQ_DATA_W 32

// Opaque ALU command width
`define ISQ_ALU_CMD_W 4

`endif

// ==== isq_pkg.sv ====
`default_nettype none

`include "isq_cfg.svh"

package isq_pkg;

  typedef logic [`ISQ_PREG_AW-1:0]                preg_t;
  typedef logic [`ISQ_ROB_AW-1:0]                 rob_t;
  typedef logic [`ISQ_DATA_W-1:0]                 data_t;     // Low bits hold a tag while op2 waits
  typedef logic [`ISQ_ALU_CMD_W-1:0]              alu_cmd_t;
  typedef logic [$clog2(`ISQ_DISPATCH_WIDTH)-1:0] bank_t;
  typedef logic [$clog2(`ISQ_SIZE)-1:0]           isq_idx_t;
  typedef logic [`ISQ_SIZE-1:0]                   isq_mask_t; // One bit per entry

  typedef struct packed {
    logic     en;
    alu_cmd_t alu_cmd;
    logic     op1_valid;
    preg_t    op1;
    logic     op2_valid;
    logic     op2_is_imm;
    data_t    op2;
    preg_t    phys_rd;
    bank_t    bank;                                            // Target ALU bank
    rob_t     rob;
  } dispatch_t;

  typedef struct packed {
    logic  valid;
    preg_t phys_rd;
    data_t data;
  } wb_t;

  typedef struct packed {
    logic     valid;
    alu_cmd_t alu_cmd;
    preg_t    op1;
    logic     op2_is_imm;
    data_t    op2;
    preg_t    phys_rd;
    rob_t     rob;
  } issue_t;

  // Stored micro-op, dispatch fields without en
  typedef struct packed {
    logic     busy;
    alu_cmd_t alu_cmd;
    logic     op1_valid;
    preg_t    op1;
    logic     op2_valid;
    logic     op2_is_imm;
    data_t    op2;
    preg_t    phys_rd;
    bank_t    bank;
    rob_t     rob;
  } isq_entry_t;

endpackage

`default_nettype wire

// ==== isq_free_list.sv ====
`default_nettype none
`timescale 1ns/1ps

`include "isq_cfg.svh"

module isq_free_list (
  input  wire                            clk,
  input  wire                            rst_n,
  input  wire isq_pkg::isq_mask_t        busy,
  input  wire [`ISQ_DISPATCH_WIDTH-1:0]  dispatch_en,
  output logic [`ISQ_DISPATCH_WIDTH-1:0] grant_valid,
  output isq_pkg::isq_idx_t              grant_idx [`ISQ_DISPATCH_WIDTH],
  output logic                           full
);

  isq_pkg::isq_mask_t              free;
  logic [$clog2(`ISQ_SIZE+1)-1:0]  free_cnt;

  always_comb begin
    free = ~busy;
    free_cnt = '0;
    for (int i = 0; i < `ISQ_SIZE; i++) begin
      free_cnt += free[i];
    end
    full = (free_cnt < `ISQ_DISPATCH_WIDTH);  // Needs room for a full dispatch group
  end

  // Lowest free slot goes to the first enabled lane and the next one to the following lane
  always_comb begin
    isq_pkg::isq_mask_t avail;
    avail = free;
    grant_valid = '0;
    for (int l = 0; l < `ISQ_DISPATCH_WIDTH; l++) begin
      grant_idx[l] = '0;
      for (int i = `ISQ_SIZE - 1; i >= 0; i--) begin
        if (avail[i]) begin
          grant_idx[l] = isq_pkg::isq_idx_t'(i);
        end
      end
      if (dispatch_en[l] && !full) begin
        grant_valid[l] = 1'b1;
        avail[grant_idx[l]] = 1'b0;
      end
    end
  end

endmodule

`default_nettype wire

// ==== isq_storage.sv ====
`default_nettype none
`timescale 1ns/1ps

`include "isq_cfg.svh"

module isq_storage (
  input  wire                           clk,
  input  wire                           rst_n,
  input  wire isq_pkg::dispatch_t       dispatch [`ISQ_DISPATCH_WIDTH],
  input  wire [`ISQ_DISPATCH_WIDTH-1:0] grant_valid,
  input  wire isq_pkg::isq_idx_t        grant_idx [`ISQ_DISPATCH_WIDTH],
  input  wire isq_pkg::wb_t             wb [`ISQ_DISPATCH_WIDTH],
  input  wire isq_pkg::isq_mask_t       release_mask,
  output isq_pkg::isq_entry_t           entries [`ISQ_SIZE],
  output isq_pkg::isq_mask_t            ready,
  output isq_pkg::isq_mask_t            older [`ISQ_SIZE]
);

  isq_pkg::isq_mask_t  busy_q;
  isq_pkg::isq_entry_t slot_q [`ISQ_SIZE];
  isq_pkg::isq_mask_t  older_q [`ISQ_SIZE];              // Bit j set when slot j is older
  isq_pkg::isq_entry_t incoming [`ISQ_DISPATCH_WIDTH];
  isq_pkg::isq_mask_t  lane_older [`ISQ_DISPATCH_WIDTH];
  isq_pkg::isq_mask_t  alloc_mask;
  isq_pkg::isq_mask_t  staying;

  // Applies every valid writeback port to one entry
  function automatic isq_pkg::isq_entry_t wake(
    input isq_pkg::isq_entry_t e,
    input isq_pkg::wb_t        w [`ISQ_DISPATCH_WIDTH]
  );
    isq_pkg::isq_entry_t r;
    r = e;
    for (int p = 0; p < `ISQ_DISPATCH_WIDTH; p++) begin
      if (w[p].valid) begin
        if (!r.op1_valid && r.op1 == w[p].phys_rd) begin
          r.op1_valid = 1'b1;
        end
        if (!r.op2_valid && !r.op2_is_imm && r.op2[`ISQ_PREG_AW-1:0] == w[p].phys_rd) begin
          r.op2_valid = 1'b1;
          r.op2 = w[p].data;                           // Tag replaced by the value
        end
      end
    end
    return r;
  endfunction

  // Dispatch lanes see the same broadcast as the stored entries
  always_comb begin
    for (int l = 0; l < `ISQ_DISPATCH_WIDTH; l++) begin
      incoming[l].busy       = 1'b1;
      incoming[l].alu_cmd    = dispatch[l].alu_cmd;
      incoming[l].op1_valid  = dispatch[l].op1_valid;
      incoming[l].op1        = dispatch[l].op1;
      incoming[l].op2_valid  = dispatch[l].op2_valid;
      incoming[l].op2_is_imm = dispatch[l].op2_is_imm;
      incoming[l].op2        = dispatch[l].op2;
      incoming[l].phys_rd    = dispatch[l].phys_rd;
      incoming[l].bank       = dispatch[l].bank;
      incoming[l].rob        = dispatch[l].rob;
      incoming[l] = wake(incoming[l], wb);
    end
  end

  always_comb begin
    staying = busy_q & ~release_mask;
    alloc_mask = '0;
    for (int l = 0; l < `ISQ_DISPATCH_WIDTH; l++) begin
      lane_older[l] = staying | alloc_mask;           // Earlier lanes count as older
      if (grant_valid[l]) begin
        alloc_mask[grant_idx[l]] = 1'b1;
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      busy_q <= '0;
    end else begin
      busy_q <= staying | alloc_mask;
    end
  end

  always_ff @(posedge clk) begin
    for (int i = 0; i < `ISQ_SIZE; i++) begin
      if (busy_q[i]) begin
        slot_q[i] <= wake(slot_q[i], wb);
      end
    end
    for (int l = 0; l < `ISQ_DISPATCH_WIDTH; l++) begin
      if (grant_valid[l]) begin
        slot_q[grant_idx[l]] <= incoming[l];
      end
    end
  end

  // New slots are younger than everything, so their column is cleared in all rows
  always_ff @(posedge clk) begin
    for (int i = 0; i < `ISQ_SIZE; i++) begin
      older_q[i] <= older_q[i] & ~alloc_mask;
    end
    for (int l = 0; l < `ISQ_DISPATCH_WIDTH; l++) begin
      if (grant_valid[l]) begin
        older_q[grant_idx[l]] <= lane_older[l];
      end
    end
  end

  always_comb begin
    for (int i = 0; i < `ISQ_SIZE; i++) begin
      entries[i]      = slot_q[i];
      entries[i].busy = busy_q[i];
      ready[i]        = busy_q[i] && slot_q[i].op1_valid && slot_q[i].op2_valid;
      older[i]        = older_q[i];
    end
  end

endmodule

`default_nettype wire

// ==== isq_select.sv ====
`default_nettype none
`timescale 1ns/1ps

`include "isq_cfg.svh"

module isq_select (
  input  wire isq_pkg::isq_mask_t        ready,
  input  wire isq_pkg::isq_entry_t       entries [`ISQ_SIZE],
  input  wire isq_pkg::isq_mask_t        older [`ISQ_SIZE],
  output logic [`ISQ_DISPATCH_WIDTH-1:0] pick_valid,
  output isq_pkg::isq_idx_t              pick_idx [`ISQ_DISPATCH_WIDTH]
);

  isq_pkg::isq_mask_t bank_ready [`ISQ_DISPATCH_WIDTH];  // Ready entries steered to a bank
  isq_pkg::isq_mask_t oldest [`ISQ_DISPATCH_WIDTH];

  always_comb begin
    for (int b = 0; b < `ISQ_DISPATCH_WIDTH; b++) begin
      for (int i = 0; i < `ISQ_SIZE; i++) begin
        bank_ready[b][i] = ready[i] && (entries[i].bank == isq_pkg::bank_t'(b));
      end
    end
  end

  // At most one bit survives per bank since the age matrix is a total order
  always_comb begin
    for (int b = 0; b < `ISQ_DISPATCH_WIDTH; b++) begin
      for (int i = 0; i < `ISQ_SIZE; i++) begin
        oldest[b][i] = bank_ready[b][i] && !(|(older[i] & bank_ready[b]));
      end
    end
  end

  always_comb begin
    for (int b = 0; b < `ISQ_DISPATCH_WIDTH; b++) begin
      pick_valid[b] = |oldest[b];
      pick_idx[b] = '0;
      for (int i = 0; i < `ISQ_SIZE; i++) begin
        if (oldest[b][i]) begin
          pick_idx[b] = isq_pkg::isq_idx_t'(i);
        end
      end
    end
  end

endmodule

`default_nettype wire

// ==== issue_queue.sv ====
`default_nettype none
`timescale 1ns/1ps

`include "isq_cfg.svh"

module issue_queue (
  input  wire                     clk,
  input  wire                     rst_n,
  input  wire isq_pkg::dispatch_t dispatch [`ISQ_DISPATCH_WIDTH],
  output logic                    full,
  input  wire isq_pkg::wb_t       wb [`ISQ_DISPATCH_WIDTH],
  output isq_pkg::issue_t         issue [`ISQ_DISPATCH_WIDTH]
);

  logic [`ISQ_DISPATCH_WIDTH-1:0] dispatch_en;
  logic [`ISQ_DISPATCH_WIDTH-1:0] grant_valid;
  logic [`ISQ_DISPATCH_WIDTH-1:0] pick_valid;
  logic [`ISQ_DISPATCH_WIDTH-1:0] issue_valid_q;
  isq_pkg::isq_idx_t              grant_idx [`ISQ_DISPATCH_WIDTH];
  isq_pkg::isq_idx_t              pick_idx [`ISQ_DISPATCH_WIDTH];
  isq_pkg::issue_t                picked [`ISQ_DISPATCH_WIDTH];
  isq_pkg::issue_t                issue_q [`ISQ_DISPATCH_WIDTH];
  isq_pkg::isq_mask_t             busy;
  isq_pkg::isq_mask_t             ready;
  isq_pkg::isq_mask_t             release_mask;
  isq_pkg::isq_entry_t            entries [`ISQ_SIZE];
  isq_pkg::isq_mask_t             older [`ISQ_SIZE];

  always_comb begin
    for (int l = 0; l < `ISQ_DISPATCH_WIDTH; l++) begin
      dispatch_en[l] = dispatch[l].en;
    end
    for (int i = 0; i < `ISQ_SIZE; i++) begin
      busy[i] = entries[i].busy;
    end
  end

  isq_free_list u_free_list (
    .clk         (clk),
    .rst_n       (rst_n),
    .busy        (busy),
    .dispatch_en (dispatch_en),
    .grant_valid (grant_valid),
    .grant_idx   (grant_idx),
    .full        (full)
  );

  isq_storage u_storage (
    .clk          (clk),
    .rst_n        (rst_n),
    .dispatch     (dispatch),
    .grant_valid  (grant_valid),
    .grant_idx    (grant_idx),
    .wb           (wb),
    .release_mask (release_mask),
    .entries      (entries),
    .ready        (ready),
    .older        (older)
  );

  isq_select u_select (
    .ready      (ready),
    .entries    (entries),
    .older      (older),
    .pick_valid (pick_valid),
    .pick_idx   (pick_idx)
  );

  // Picked entries leave the queue at the same edge they move into issue
  always_comb begin
    release_mask = '0;
    for (int b = 0; b < `ISQ_DISPATCH_WIDTH; b++) begin
      picked[b].valid      = 1'b1;
      picked[b].alu_cmd    = entries[pick_idx[b]].alu_cmd;
      picked[b].op1        = entries[pick_idx[b]].op1;
      picked[b].op2_is_imm = entries[pick_idx[b]].op2_is_imm;
      picked[b].op2        = entries[pick_idx[b]].op2;
      picked[b].phys_rd    = entries[pick_idx[b]].phys_rd;
      picked[b].rob        = entries[pick_idx[b]].rob;
      if (pick_valid[b]) begin
        release_mask[pick_idx[b]] = 1'b1;
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      issue_valid_q <= '0;
    end else begin
      issue_valid_q <= pick_valid;  // One cycle per issued micro-op
    end
  end

  always_ff @(posedge clk) begin
    for (int b = 0; b < `ISQ_DISPATCH_WIDTH; b++) begin
      if (pick_valid[b]) begin
        issue_q[b] <= picked[b];
      end
    end
  end

  always_comb begin
    for (int b = 0; b < `ISQ_DISPATCH_WIDTH; b++) begin
      issue[b]       = issue_q[b];
      issue[b].valid = issue_valid_q[b];
    end
  end

endmodule

`default_nettype wire

// ==== tb_clk_gen.sv ====
`default_nettype none
`timescale 1ns/1ps

module tb_clk_gen (
  output logic clk,
  output logic rst_n
);

  localparam int HALF_PERIOD = 4;  // 8 ns clock

  initial begin
    clk = 1'b0;
    forever #(HALF_PERIOD) clk = ~clk;
  end

  // Held low over the first two rising edges
  initial begin
    rst_n = 1'b0;
    repeat (2) @(posedge clk);
    #1 rst_n = 1'b1;
  end

endmodule

`default_nettype wire

// ==== tb_issue_queue.sv ====
`default_nettype none
`timescale 1ns/1ps

`include "isq_cfg.svh"

module tb_issue_queue;

  localparam int PERIOD   = 8;
  localparam int NUM_ROWS = 27;
  localparam int TIMEOUT  = (NUM_ROWS + 2 + 20) * PERIOD;  // Rows plus reset plus margin

  // One cycle of stimulus and the responses expected in that cycle
  typedef struct packed {
    isq_pkg::dispatch_t [`ISQ_DISPATCH_WIDTH-1:0] disp;
    isq_pkg::wb_t       [`ISQ_DISPATCH_WIDTH-1:0] wb;
    logic                                         full;
    isq_pkg::issue_t    [`ISQ_DISPATCH_WIDTH-1:0] issue;
  } row_t;

  logic               clk;
  logic               rst_n;
  logic               full;
  isq_pkg::dispatch_t dispatch [`ISQ_DISPATCH_WIDTH];
  isq_pkg::wb_t       wb [`ISQ_DISPATCH_WIDTH];
  isq_pkg::issue_t    issue [`ISQ_DISPATCH_WIDTH];
  row_t               rows [NUM_ROWS];
  int                 errors;
  int                 checks;

  tb_clk_gen u_clk_gen (
    .clk   (clk),
    .rst_n (rst_n)
  );

  issue_queue dut (
    .clk      (clk),
    .rst_n    (rst_n),
    .dispatch (dispatch),
    .full     (full),
    .wb       (wb),
    .issue    (issue)
  );

  task automatic put_dispatch(input int r, input int lane, input isq_pkg::alu_cmd_t cmd,
                              input logic op1_valid, input isq_pkg::preg_t op1,
                              input logic op2_valid, input logic op2_is_imm,
                              input isq_pkg::data_t op2, input isq_pkg::preg_t phys_rd,
                              input isq_pkg::bank_t bank, input isq_pkg::rob_t rob);
    rows[r].disp[lane].en         = 1'b1;
    rows[r].disp[lane].alu_cmd    = cmd;
    rows[r].disp[lane].op1_valid  = op1_valid;
    rows[r].disp[lane].op1        = op1;
    rows[r].disp[lane].op2_valid  = op2_valid;
    rows[r].disp[lane].op2_is_imm = op2_is_imm;
    rows[r].disp[lane].op2        = op2;
    rows[r].disp[lane].phys_rd    = phys_rd;
    rows[r].disp[lane].bank       = bank;
    rows[r].disp[lane].rob        = rob;
  endtask

  task automatic put_wb(input int r, input int port, input isq_pkg::preg_t tag,
                        input isq_pkg::data_t data);
    rows[r].wb[port].valid   = 1'b1;
    rows[r].wb[port].phys_rd = tag;
    rows[r].wb[port].data    = data;
  endtask

  // Issue carries the dispatched fields, op2 is the value after any wakeup
  task automatic expect_issue(input int r, input int b, input int src_r, input int src_l,
                              input isq_pkg::data_t op2);
    isq_pkg::dispatch_t d;
    d = rows[src_r].disp[src_l];
    rows[r].issue[b].valid      = 1'b1;
    rows[r].issue[b].alu_cmd    = d.alu_cmd;
    rows[r].issue[b].op1        = d.op1;
    rows[r].issue[b].op2_is_imm = d.op2_is_imm;
    rows[r].issue[b].op2        = op2;
    rows[r].issue[b].phys_rd    = d.phys_rd;
    rows[r].issue[b].rob        = d.rob;
  endtask

  task automatic build_rows();
    foreach (rows[r]) begin
      rows[r] = '0;
    end
    // Both operands ready, one per bank
    put_dispatch(1, 0, 4'h1, 1'b1, 6'd5, 1'b1, 1'b1, 32'h0000_0011, 6'd10, 1'b0, 5'd1);
    put_dispatch(1, 1, 4'h2, 1'b1, 6'd6, 1'b1, 1'b0, 32'h0000_0022, 6'd11, 1'b1, 5'd2);
    expect_issue(3, 0, 1, 0, 32'h0000_0011);
    expect_issue(3, 1, 1, 1, 32'h0000_0022);
    // Waiting on tags, the immediate's low bits alias tag 22
    put_dispatch(3, 0, 4'h3, 1'b0, 6'd20, 1'b0, 1'b0, 32'h0000_0015, 6'd12, 1'b0, 5'd3);
    put_dispatch(3, 1, 4'h4, 1'b0, 6'd22, 1'b1, 1'b1, 32'h0000_0116, 6'd13, 1'b1, 5'd4);
    put_wb(4, 0, 6'd20, 32'h1111_0000);
    put_wb(5, 1, 6'd22, 32'h0000_0055);
    put_wb(6, 0, 6'd21, 32'hdead_beef);
    expect_issue(7, 1, 3, 1, 32'h0000_0116);
    expect_issue(8, 0, 3, 0, 32'hdead_beef);
    // Wakeup together with dispatch
    put_dispatch(8, 0, 4'h5, 1'b0, 6'd30, 1'b0, 1'b0, 32'h0000_001f, 6'd14, 1'b1, 5'd5);
    put_wb(8, 0, 6'd30, 32'h0000_0001);
    put_wb(8, 1, 6'd31, 32'h3333_4444);
    expect_issue(10, 1, 8, 0, 32'h3333_4444);
    // Oldest first on bank 0, the last one lands in a lower slot
    put_dispatch(10, 0, 4'h6, 1'b1, 6'd1, 1'b1, 1'b1, 32'h0000_0a01, 6'd15, 1'b0, 5'd6);
    put_dispatch(10, 1, 4'h7, 1'b1, 6'd2, 1'b1, 1'b1, 32'h0000_0a02, 6'd16, 1'b0, 5'd7);
    put_dispatch(11, 0, 4'h8, 1'b1, 6'd3, 1'b1, 1'b1, 32'h0000_0a03, 6'd17, 1'b0, 5'd8);
    put_dispatch(11, 1, 4'h9, 1'b1, 6'd4, 1'b1, 1'b1, 32'h0000_0a04, 6'd18, 1'b1, 5'd9);
    put_dispatch(12, 0, 4'ha, 1'b1, 6'd7, 1'b1, 1'b1, 32'h0000_0a05, 6'd19, 1'b0, 5'd10);
    expect_issue(12, 0, 10, 0, 32'h0000_0a01);
    expect_issue(13, 0, 10, 1, 32'h0000_0a02);
    expect_issue(13, 1, 11, 1, 32'h0000_0a04);
    expect_issue(14, 0, 11, 0, 32'h0000_0a03);
    expect_issue(15, 0, 12, 0, 32'h0000_0a05);
    // Seven entries wait on tag 40, alternating banks
    for (int k = 0; k < 7; k++) begin
      put_dispatch(15 + k / 2, k % 2, 4'hb, 1'b0, 6'd40, 1'b1, 1'b1, 32'h100 + k,
                   6'd20 + k, k % 2, 5'd11 + k);
      expect_issue(22 + k / 2, k % 2, 15 + k / 2, k % 2, 32'h100 + k);
    end
    // Only one slot free, so both lanes are dropped
    put_dispatch(19, 0, 4'hc, 1'b1, 6'd8, 1'b1, 1'b1, 32'h0000_0bad, 6'd30, 1'b1, 5'd20);
    put_dispatch(19, 1, 4'hd, 1'b1, 6'd9, 1'b1, 1'b1, 32'h0000_0bad, 6'd31, 1'b0, 5'd21);
    put_wb(20, 0, 6'd40, 32'h4040_4040);
    rows[19].full = 1'b1;
    rows[20].full = 1'b1;
    rows[21].full = 1'b1;
  endtask

  task automatic apply_row(input int r);
    for (int l = 0; l < `ISQ_DISPATCH_WIDTH; l++) begin
      dispatch[l] = rows[r].disp[l];
      wb[l]       = rows[r].wb[l];
    end
  endtask

  task automatic check_row(input int r);
    row_t e;
    e = rows[r];
    checks++;
    assert (full === e.full) else begin
      errors++;
      $display("ERROR @%0t: row %0d full is %b, expected %b", $time, r, full, e.full);
    end
    for (int b = 0; b < `ISQ_DISPATCH_WIDTH; b++) begin
      checks++;
      assert (issue[b].valid === e.issue[b].valid) else begin
        errors++;
        $display("ERROR @%0t: row %0d bank %0d issue valid is %b, expected %b",
                 $time, r, b, issue[b].valid, e.issue[b].valid);
      end
      if (e.issue[b].valid) begin
        checks++;
        assert (issue[b] === e.issue[b]) else begin
          errors++;
          $display("ERROR @%0t: row %0d bank %0d issued rob %0d op2 %h, expected rob %0d op2 %h",
                   $time, r, b, issue[b].rob, issue[b].op2, e.issue[b].rob, e.issue[b].op2);
        end
      end
    end
  endtask

  initial begin
    errors = 0;
    checks = 0;
    for (int l = 0; l < `ISQ_DISPATCH_WIDTH; l++) begin
      dispatch[l] = '0;
      wb[l]       = '0;
    end
    build_rows();
    wait (rst_n === 1'b1);
    for (int r = 0; r < NUM_ROWS; r++) begin
      @(posedge clk);
      #1;
      apply_row(r);
      #(PERIOD - 2);  // Sample just before the next edge
      check_row(r);
    end
    $display("checks: %0d  errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

  initial begin
    #(TIMEOUT);
    $display("Timeout: the stimulus table did not finish within %0d ns", TIMEOUT);
    $display("SIMULATION FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== build.f ====
+incdir+.
isq_pkg.sv
isq_free_list.sv
isq_storage.sv
isq_select.sv
issue_queue.sv
tb_clk_gen.sv
tb_issue_queue.sv

// ==== Bender.yml ====
package:
  name: issue_queue

sources:
  - include_dirs:
      - .
    files:
      - isq_pkg.sv
      - isq_free_list.sv
      - isq_storage.sv
      - isq_select.sv
      - issue_queue.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_clk_gen.sv
      - tb_issue_queue.sv
